// ==== files.f ====
verilog/mem_pkg.sv
verilog/fill_engine.sv
verilog/request_arbiter.sv
verilog/pixel_feeder.sv
verilog/memory_top.sv
verif/mem_model.sv
verif/tb_memory_top.sv

// ==== verif/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  mem_pkg::mem_req_t i_req,
   input  logic              i_req_valid,
   output mem_pkg::data_t    o_rd_data,
   output logic              o_rd_valid,
   output logic              o_credit,
   output int                o_mask_errs
);

   // Word store indexed by the low address bits
   mem_pkg::data_t mem [256];
   mem_pkg::data_t rd_q [$];
   int             due_q [$];
   mem_pkg::data_t merged;
   int             cyc;
   integer         seed;

   initial begin
      seed        = 32'h7525_c449;
      cyc         = 0;
      o_rd_data   = '0;
      o_rd_valid  = 1'b0;
      o_credit    = 1'b0;
      o_mask_errs = 0;
   end

   always @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rd_q.delete();
         due_q.delete();
         o_rd_valid <= 1'b0;
         o_credit   <= 1'b0;
      end else begin
         cyc = cyc + 1;
         if (i_req_valid) begin
            // Slot is freed 1 to 8 cycles later
            due_q.push_back(cyc + 1 + ($random(seed) & 7));
            if (i_req.cmd == mem_pkg::MEM_WRITE) begin
               merged = mem[i_req.addr[7:0]];
               for (int b = 0; b < mem_pkg::MASK_W; b++) begin
                  if (!i_req.mask[b])
                     merged[b*8 +: 8] = i_req.data[b*8 +: 8];
               end
               mem[i_req.addr[7:0]] <= merged;
               if (i_req.mask != '0)
                  o_mask_errs <= o_mask_errs + 1;
            end else begin
               rd_q.push_back(mem[i_req.addr[7:0]]);
            end
         end
         // One credit pulse per cycle at most
         o_credit <= 1'b0;
         if (due_q.size() != 0 && due_q[0] <= cyc) begin
            o_credit <= 1'b1;
            due_q.delete(0);
         end
         // Read data in request order, with random gaps
         o_rd_valid <= 1'b0;
         if (rd_q.size() != 0 && ($random(seed) & 3) != 0) begin
            o_rd_valid <= 1'b1;
            o_rd_data  <= rd_q.pop_front();
         end
      end
   end

endmodule

// ==== verif/memory_input.txt ====
// One hex value per row. Rows 0-15 preload words of the first display frame,
// 16-17 display bases, 18 fill command {base, colour}, 19 fill colour, 20-23 ready gaps
03030303020202020101010100000000
13131313121212121111111110101010
23232323222222222121212120202020
33333333323232323131313130303030
43434343424242424141414140404040
53535353525252525151515150505050
63636363626262626161616160606060
73737373727272727171717170707070
83838383828282828181818180808080
93939393929292929191919190909090
a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0
b3b3b3b3b2b2b2b2b1b1b1b1b0b0b0b0
c3c3c3c3c2c2c2c2c1c1c1c1c0c0c0c0
d3d3d3d3d2d2d2d2d1d1d1d1d0d0d0d0
e3e3e3e3e2e2e2e2e1e1e1e1e0e0e0e0
f3f3f3f3f2f2f2f2f1f1f1f1f0f0f0f0
// Display bases, preloaded frame first
00010
00040
// Fill command and its colour
000403c9e1f
3c9e1f
// Video ready, bit n is ready in cycle n of each 16-cycle slot
ffff
5a5a
0f0f
c3e7

// ==== verif/tb_memory_top.sv ====
`timescale 1ns/1ps

module tb_memory_top;

   localparam int CLK_HALF   = 20;
   localparam int WAIT_LIMIT = 4000;
   localparam int FRAME_PIX  = mem_pkg::FRAME_WORDS * mem_pkg::LANES;

   logic               clk;
   logic               rst_n;
   mem_pkg::fill_cmd_t fill_cmd;
   logic               fill_valid;
   logic               fill_ready;
   mem_pkg::addr_t     display_base;
   mem_pkg::mem_req_t  mem_req;
   logic               mem_req_valid;
   logic               mem_credit;
   mem_pkg::data_t     rd_data;
   logic               rd_valid;
   mem_pkg::pixel_t    video;
   logic               video_valid;
   logic               video_ready;
   logic               frame_done;
   int                 mask_errs;

   // Rows 0-15 preload, 16-17 display bases, 18 fill command, 19 colour, 20-23 ready gaps
   logic [127:0]       vec [24];
   int                 pix_total;
   int                 frames_done;
   int                 b_from_frame;
   int                 outstanding;
   int                 ready_cyc;
   logic               done_exp;

   memory_top uut (
      .i_cpu_clk       (clk),
      .i_rst_n         (rst_n),
      .i_fill_cmd      (fill_cmd),
      .i_fill_valid    (fill_valid),
      .o_fill_ready    (fill_ready),
      .i_display_base  (display_base),
      .o_mem_req       (mem_req),
      .o_mem_req_valid (mem_req_valid),
      .i_mem_credit    (mem_credit),
      .i_rd_data       (rd_data),
      .i_rd_valid      (rd_valid),
      .o_video         (video),
      .o_video_valid   (video_valid),
      .i_video_ready   (video_ready),
      .o_frame_done    (frame_done)
   );

   mem_model u_mem (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_req       (mem_req),
      .i_req_valid (mem_req_valid),
      .o_rd_data   (rd_data),
      .o_rd_valid  (rd_valid),
      .o_credit    (mem_credit),
      .o_mask_errs (mask_errs)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
         abort_run("value check failed");
      end
   endtask

   // Frames before the switch come from the preload, later ones hold the fill colour
   function automatic mem_pkg::pixel_t expected_pixel(input int idx);
      int word;
      int lane;
      word = (idx % FRAME_PIX) / mem_pkg::LANES;
      lane = idx % mem_pkg::LANES;
      if (idx / FRAME_PIX >= b_from_frame)
         return vec[19][mem_pkg::PIXEL_W-1:0];
      return vec[word][lane*mem_pkg::LANE_W +: mem_pkg::PIXEL_W];
   endfunction

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // ----------------------------------------------------------------------------
   // Video ready gaps and the per-cycle monitor
   // ----------------------------------------------------------------------------
   always @(posedge clk) begin
      video_ready <= vec[20 + (ready_cyc / 16) % 4][ready_cyc % 16];
      ready_cyc   <= ready_cyc + 1;
   end

   always @(posedge clk) begin
      if (rst_n) begin
         outstanding = outstanding + int'(mem_req_valid) - int'(mem_credit);
         check_value("credit limit", 1, outstanding <= mem_pkg::MEM_CREDITS);
         check_value("frame_done", done_exp, frame_done);
         if (frame_done)
            frames_done = frames_done + 1;
         done_exp = 1'b0;
         if (video_valid && video_ready) begin
            check_value("pixel", expected_pixel(pix_total), video);
            pix_total = pix_total + 1;
            done_exp  = (pix_total % FRAME_PIX == 0);
         end
      end
   end

   // ----------------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------------
   initial begin
      int t;
      int start;
      $readmemh("verif/memory_input.txt", vec);
      rst_n        = 1'b0;
      fill_cmd     = '0;
      fill_valid   = 1'b0;
      display_base = vec[16][mem_pkg::ADDR_W-1:0];
      video_ready  = 1'b0;
      pix_total    = 0;
      frames_done  = 0;
      b_from_frame = 1000000;
      outstanding  = 0;
      ready_cyc    = 0;
      done_exp     = 1'b0;
      for (int a = 0; a < 256; a++)
         u_mem.mem[a] = {4{32'h5a00_0000 | a}};
      for (int k = 0; k < mem_pkg::FRAME_WORDS; k++)
         u_mem.mem[display_base[7:0] + k] = vec[k];

      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) begin
         @(negedge clk);
         check_value("reset mem_req_valid", 0, mem_req_valid);
         check_value("reset video_valid", 0, video_valid);
         check_value("reset frame_done", 0, frame_done);
         check_value("reset fill_ready", 1, fill_ready);
      end

      @(posedge clk);
      fill_cmd   <= mem_pkg::fill_cmd_t'(vec[18][43:0]);
      fill_valid <= 1'b1;
      @(posedge clk);
      fill_valid <= 1'b0;
      t = 0;
      @(negedge clk);
      while (!fill_ready) begin
         if (t == WAIT_LIMIT)
            abort_run("fill command never returned o_fill_ready");
         t++;
         @(negedge clk);
      end
      // Last write reaches the model one cycle later
      @(negedge clk);
      for (int k = 0; k < mem_pkg::FRAME_WORDS; k++)
         check_value("fill word", {4{8'h00, vec[19][23:0]}}, u_mem.mem[fill_cmd.base[7:0] + k]);

      // Switch right after a frame ends, so the frame after next reads the filled area
      start = frames_done;
      t     = 0;
      while (frames_done == start) begin
         if (t == WAIT_LIMIT)
            abort_run("no frame_done pulse after the fill");
         t++;
         @(negedge clk);
      end
      b_from_frame = frames_done + 1;
      @(posedge clk);
      display_base <= vec[17][mem_pkg::ADDR_W-1:0];

      t = 0;
      while (frames_done < b_from_frame + 2) begin
         if (t == WAIT_LIMIT)
            abort_run("frames from the filled base did not complete");
         t++;
         @(negedge clk);
      end
      check_value("write masks", 0, mask_errs);
      $display("Test passed");
      $finish;
   end

endmodule

// ==== verilog/fill_engine.sv ====
`timescale 1ns/1ps

module fill_engine (
   input  logic               i_cpu_clk,
   input  logic               i_rst_n,
   input  mem_pkg::fill_cmd_t i_fill_cmd,
   input  logic               i_fill_valid,
   input  logic               i_grant,
   output logic               o_fill_ready,
   output mem_pkg::mem_req_t  o_req,
   output logic               o_req_valid
);

   typedef enum logic {
      FILL_IDLE,
      FILL_WRITE
   } fill_state_e;

   fill_state_e                 state_q;
   mem_pkg::fill_cmd_t          cmd_q;
   mem_pkg::word_cnt_t          word_q;
   logic                        last_word;
   logic [mem_pkg::LANE_W-1:0]  lane_pix;

   assign last_word    = (word_q == mem_pkg::word_cnt_t'(mem_pkg::FRAME_WORDS - 1));
   assign o_fill_ready = (state_q == FILL_IDLE);
   assign o_req_valid  = (state_q == FILL_WRITE);

   // One lane of colour, top byte zero
   assign lane_pix = {{(mem_pkg::LANE_W - mem_pkg::PIXEL_W){1'b0}}, cmd_q.color};

   always_comb begin
      o_req.cmd  = mem_pkg::MEM_WRITE;
      o_req.addr = cmd_q.base + mem_pkg::addr_t'(word_q);
      o_req.data = {mem_pkg::LANES{lane_pix}};
      o_req.mask = '0;
   end

   always_ff @(posedge i_cpu_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= FILL_IDLE;
         word_q  <= '0;
      end else begin
         case (state_q)
            FILL_IDLE: begin
               if (i_fill_valid) begin
                  state_q <= FILL_WRITE;
                  word_q  <= '0;
               end
            end
            FILL_WRITE: begin
               // Walk the frame one granted word at a time
               if (i_grant) begin
                  word_q <= word_q + 1'b1;
                  if (last_word) begin
                     state_q <= FILL_IDLE;
                  end
               end
            end
            default: state_q <= FILL_IDLE;
         endcase
      end
   end

   // Command held for the whole fill
   always_ff @(posedge i_cpu_clk) begin
      if (o_fill_ready && i_fill_valid) begin
         cmd_q <= i_fill_cmd;
      end
   end

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

   // ------------------------------------------------------------------------
   // Memory word and frame geometry
   // ------------------------------------------------------------------------
   localparam int ADDR_W         = 20;
   localparam int DATA_W         = 128;
   localparam int MASK_W         = DATA_W / 8;
   localparam int PIXEL_W        = 24;
   localparam int LANES          = 4;
   localparam int LANE_W         = DATA_W / LANES;
   localparam int FRAME_WORDS    = 16;
   localparam int MEM_CREDITS    = 4;
   localparam int FEED_BUF_WORDS = 4;

   // Derived counter widths
   localparam int WORD_CNT_W = $clog2(FRAME_WORDS);
   localparam int CREDIT_W   = $clog2(MEM_CREDITS + 1);
   localparam int BUF_IDX_W  = $clog2(FEED_BUF_WORDS);
   localparam int BUF_CNT_W  = $clog2(FEED_BUF_WORDS + 1);
   localparam int LANE_IDX_W = $clog2(LANES);

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   // Set bit means the byte is left untouched
   typedef logic [MASK_W-1:0]     mask_t;
   typedef logic [PIXEL_W-1:0]    pixel_t;
   typedef logic [WORD_CNT_W-1:0] word_cnt_t;
   typedef logic [CREDIT_W-1:0]   credit_t;
   typedef logic [BUF_IDX_W-1:0]  buf_idx_t;
   typedef logic [BUF_CNT_W-1:0]  buf_cnt_t;
   typedef logic [LANE_IDX_W-1:0] lane_idx_t;

   // Same encoding as the DDR2 address FIFO commands
   typedef enum logic [2:0] {
      MEM_WRITE = 3'b000,
      MEM_READ  = 3'b001
   } mem_cmd_e;

   // ------------------------------------------------------------------------
   // Bundles
   // ------------------------------------------------------------------------
   typedef struct packed {
      mem_cmd_e cmd;
      addr_t    addr;
      data_t    data;
      mask_t    mask;
   } mem_req_t;

   typedef struct packed {
      addr_t  base;
      pixel_t color;
   } fill_cmd_t;

endpackage

// ==== verilog/memory_top.sv ====
`timescale 1ns/1ps

module memory_top (
   input  logic               i_cpu_clk,
   input  logic               i_rst_n,
   // Fill commands
   input  mem_pkg::fill_cmd_t i_fill_cmd,
   input  logic               i_fill_valid,
   output logic               o_fill_ready,
   input  mem_pkg::addr_t     i_display_base,
   // Memory request port, credit based
   output mem_pkg::mem_req_t  o_mem_req,
   output logic               o_mem_req_valid,
   input  logic               i_mem_credit,
   input  mem_pkg::data_t     i_rd_data,
   input  logic               i_rd_valid,
   // Video stream
   output mem_pkg::pixel_t    o_video,
   output logic               o_video_valid,
   input  logic               i_video_ready,
   output logic               o_frame_done
);

   mem_pkg::mem_req_t fill_req;
   logic              fill_req_valid;
   logic              write_grant;
   mem_pkg::mem_req_t feed_req;
   logic              feed_req_valid;
   logic              read_grant;

   fill_engine u_fill (
      .i_cpu_clk    (i_cpu_clk),
      .i_rst_n      (i_rst_n),
      .i_fill_cmd   (i_fill_cmd),
      .i_fill_valid (i_fill_valid),
      .i_grant      (write_grant),
      .o_fill_ready (o_fill_ready),
      .o_req        (fill_req),
      .o_req_valid  (fill_req_valid)
   );

   request_arbiter u_arb (
      .i_cpu_clk       (i_cpu_clk),
      .i_rst_n         (i_rst_n),
      .i_read_req      (feed_req),
      .i_read_valid    (feed_req_valid),
      .i_write_req     (fill_req),
      .i_write_valid   (fill_req_valid),
      .i_mem_credit    (i_mem_credit),
      .o_read_grant    (read_grant),
      .o_write_grant   (write_grant),
      .o_mem_req       (o_mem_req),
      .o_mem_req_valid (o_mem_req_valid)
   );

   pixel_feeder u_feed (
      .i_cpu_clk      (i_cpu_clk),
      .i_rst_n        (i_rst_n),
      .i_display_base (i_display_base),
      .i_grant        (read_grant),
      .i_rd_data      (i_rd_data),
      .i_rd_valid     (i_rd_valid),
      .i_video_ready  (i_video_ready),
      .o_req          (feed_req),
      .o_req_valid    (feed_req_valid),
      .o_video        (o_video),
      .o_video_valid  (o_video_valid),
      .o_frame_done   (o_frame_done)
   );

endmodule

// ==== verilog/pixel_feeder.sv ====
`timescale 1ns/1ps

module pixel_feeder (
   input  logic              i_cpu_clk,
   input  logic              i_rst_n,
   input  mem_pkg::addr_t    i_display_base,
   input  logic              i_grant,
   input  mem_pkg::data_t    i_rd_data,
   input  logic              i_rd_valid,
   input  logic              i_video_ready,
   output mem_pkg::mem_req_t o_req,
   output logic              o_req_valid,
   output mem_pkg::pixel_t   o_video,
   output logic              o_video_valid,
   output logic              o_frame_done
);

   typedef enum logic {
      FEED_IDLE,
      FEED_SCAN
   } feed_state_e;

   feed_state_e         state_q;
   mem_pkg::addr_t      rd_base_q;
   mem_pkg::word_cnt_t  rd_word_q;
   mem_pkg::word_cnt_t  out_word_q;
   mem_pkg::buf_cnt_t   occ_q;
   mem_pkg::buf_cnt_t   held_q;
   mem_pkg::buf_idx_t   wr_ptr_q;
   mem_pkg::buf_idx_t   rd_ptr_q;
   mem_pkg::lane_idx_t  lane_q;
   mem_pkg::data_t      buf_mem [mem_pkg::FEED_BUF_WORDS];
   logic                start_frame;
   logic                rd_last;
   logic                xfer;
   logic                word_pop;
   logic                frame_last;

   // ------------------------------------------------------------------------
   // Read request side
   // ------------------------------------------------------------------------
   assign rd_last     = i_grant && (rd_word_q == mem_pkg::word_cnt_t'(mem_pkg::FRAME_WORDS - 1));
   assign start_frame = (state_q == FEED_IDLE) || rd_last;

   // occ_q covers words in flight plus words sitting in the buffer
   assign o_req_valid = (state_q == FEED_SCAN) &&
                        (occ_q < mem_pkg::buf_cnt_t'(mem_pkg::FEED_BUF_WORDS));

   always_comb begin
      o_req.cmd  = mem_pkg::MEM_READ;
      o_req.addr = rd_base_q + mem_pkg::addr_t'(rd_word_q);
      o_req.data = '0;
      o_req.mask = '1;
   end

   always_ff @(posedge i_cpu_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q   <= FEED_IDLE;
         rd_word_q <= '0;
      end else begin
         state_q <= FEED_SCAN;
         if (rd_last) begin
            rd_word_q <= '0;
         end else if (i_grant) begin
            rd_word_q <= rd_word_q + 1'b1;
         end
      end
   end

   // Base is picked up at the start of each frame
   always_ff @(posedge i_cpu_clk) begin
      if (start_frame) begin
         rd_base_q <= i_display_base;
      end
   end

   // ------------------------------------------------------------------------
   // Word buffer and video output
   // ------------------------------------------------------------------------
   assign o_video_valid = (held_q != '0);
   assign o_video       = buf_mem[rd_ptr_q][lane_q * mem_pkg::LANE_W +: mem_pkg::PIXEL_W];
   assign xfer          = o_video_valid && i_video_ready;
   assign word_pop      = xfer && (lane_q == mem_pkg::lane_idx_t'(mem_pkg::LANES - 1));
   assign frame_last    = word_pop &&
                          (out_word_q == mem_pkg::word_cnt_t'(mem_pkg::FRAME_WORDS - 1));

   always_ff @(posedge i_cpu_clk) begin
      if (i_rd_valid) begin
         buf_mem[wr_ptr_q] <= i_rd_data;
      end
   end

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge i_cpu_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         occ_q        <= '0;
         held_q       <= '0;
         wr_ptr_q     <= '0;
         rd_ptr_q     <= '0;
         lane_q       <= '0;
         out_word_q   <= '0;
         o_frame_done <= 1'b0;
      end else begin
         case ({i_grant, word_pop})
            2'b10:   occ_q <= occ_q + 1'b1;
            2'b01:   occ_q <= occ_q - 1'b1;
            default: occ_q <= occ_q;
         endcase
         case ({i_rd_valid, word_pop})
            2'b10:   held_q <= held_q + 1'b1;
            2'b01:   held_q <= held_q - 1'b1;
            default: held_q <= held_q;
         endcase
         if (i_rd_valid) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (word_pop) begin
            rd_ptr_q   <= rd_ptr_q + 1'b1;
            out_word_q <= frame_last ? '0 : out_word_q + 1'b1;
         end
         if (xfer) begin
            lane_q <= lane_q + 1'b1;
         end
         o_frame_done <= frame_last;
      end
   end

endmodule

// ==== verilog/request_arbiter.sv ====
`timescale 1ns/1ps

module request_arbiter (
   input  logic              i_cpu_clk,
   input  logic              i_rst_n,
   input  mem_pkg::mem_req_t i_read_req,
   input  logic              i_read_valid,
   input  mem_pkg::mem_req_t i_write_req,
   input  logic              i_write_valid,
   input  logic              i_mem_credit,
   output logic              o_read_grant,
   output logic              o_write_grant,
   output mem_pkg::mem_req_t o_mem_req,
   output logic              o_mem_req_valid
);

   mem_pkg::credit_t credit_q;
   logic             has_credit;
   logic             spend;

   // ------------------------------------------------------------------------
   // Grant
   // ------------------------------------------------------------------------
   assign has_credit = (credit_q != '0);

   // Feeder reads have fixed priority so the video never starves
   assign o_read_grant  = has_credit && i_read_valid;
   assign o_write_grant = has_credit && i_write_valid && !i_read_valid;
   assign spend         = o_read_grant || o_write_grant;

   // ------------------------------------------------------------------------
   // Credit counter
   // ------------------------------------------------------------------------
   // Credit is taken at grant time, one cycle ahead of the valid on the port,
   // so a returned credit and a new grant can meet in the same cycle
   always_ff @(posedge i_cpu_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         credit_q <= mem_pkg::credit_t'(mem_pkg::MEM_CREDITS);
      end else begin
         case ({spend, i_mem_credit})
            2'b10:   credit_q <= credit_q - 1'b1;
            2'b01:   credit_q <= credit_q + 1'b1;
            default: credit_q <= credit_q;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Registered memory port
   // ------------------------------------------------------------------------
   always_ff @(posedge i_cpu_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_mem_req_valid <= 1'b0;
      end else begin
         o_mem_req_valid <= spend;
      end
   end

   always_ff @(posedge i_cpu_clk) begin
      if (spend) begin
         o_mem_req <= o_read_grant ? i_read_req : i_write_req;
      end
   end

endmodule
